//--- lsu.f
source/lsu_cfg_pkg.sv
source/lsu_ctl_pkg.sv
source/lsu_issue_queue.sv
source/lsu_replay_queue.sv
source/lsu_pipe.sv
source/lsu_top.sv
tests/lsu_pipe_chk.sv
tests/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the LSU testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsu_tb -f lsu.f -o lsu_sim

./obj_dir/lsu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

//--- tests/lsu_tb.sv
// LSU testbench: directed tests against a Wishbone memory model with retries
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
  import lsu_cfg_pkg::*;
  import lsu_ctl_pkg::*;
;

  localparam int          IQ_DEPTH    = 4;
  localparam int          RQ_DEPTH    = 4;
  localparam int          MEM_WORDS   = 256;
  localparam int          ID_RANGE    = 1 << CMT_ID_W;
  localparam int          TIMEOUT_CYC = 200;
  localparam int          DRAIN_CYC   = 8;
  localparam logic [31:0] SEED        = 32'h2e095c57;

  logic             i_clk;
  logic             i_arst_n;
  logic             i_disp_valid;
  lsu_op_e          i_disp_op;
  cmt_id_t          i_disp_cmt_id;
  addr_t            i_disp_addr;
  data_t            i_disp_data;
  logic             o_disp_ready;
  logic             o_wb_cyc, o_wb_stb, o_wb_we;
  addr_t            o_wb_adr;
  data_t            o_wb_dat;
  logic [SEL_W-1:0] o_wb_sel;
  data_t            i_wb_dat;
  logic             i_wb_ack, i_wb_rty;
  logic             o_done_valid, o_done_is_load;
  cmt_id_t          o_done_cmt_id;
  data_t            o_done_data;

  // Model and bookkeeping state
  data_t            mem [MEM_WORDS];
  logic             retry_on;
  logic             mem_stall;
  logic [31:0]      mem_rng = SEED;
  logic [31:0]      stim_rng = SEED;
  cmt_id_t          next_id;
  int               done_hits [ID_RANGE];
  int               hits0 [ID_RANGE];
  logic             done_is_load [ID_RANGE];
  data_t            done_data [ID_RANGE];
  cmt_id_t          done_ids [$];
  int               errors, checks, tests_run, tests_failed;

  lsu_top #(
    .IQ_DEPTH (IQ_DEPTH),
    .RQ_DEPTH (RQ_DEPTH)
  ) lsu_top_inst (
    .i_clk (i_clk), .i_arst_n (i_arst_n),
    .i_disp_valid (i_disp_valid), .i_disp_op (i_disp_op), .i_disp_cmt_id (i_disp_cmt_id),
    .i_disp_addr (i_disp_addr), .i_disp_data (i_disp_data), .o_disp_ready (o_disp_ready),
    .o_wb_cyc (o_wb_cyc), .o_wb_stb (o_wb_stb), .o_wb_we (o_wb_we), .o_wb_adr (o_wb_adr),
    .o_wb_dat (o_wb_dat), .o_wb_sel (o_wb_sel), .i_wb_dat (i_wb_dat),
    .i_wb_ack (i_wb_ack), .i_wb_rty (i_wb_rty),
    .o_done_valid (o_done_valid), .o_done_cmt_id (o_done_cmt_id),
    .o_done_is_load (o_done_is_load), .o_done_data (o_done_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Preload pattern with every byte derived from the word index
  function automatic data_t fill_word(input logic [7:0] a);
    return {a, ~a, a ^ 8'h5a, a + 8'h33};
  endfunction

  // ----------------------------------------
  // Wishbone memory model
  // ----------------------------------------
  initial begin : wb_memory_model
    int wait_left;
    i_wb_ack  = 1'b0;
    i_wb_rty  = 1'b0;
    i_wb_dat  = '0;
    wait_left = -1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(8'(i));
    end
    forever begin
      @(negedge i_clk);
      if (i_wb_ack || i_wb_rty) begin
        i_wb_ack = 1'b0;
        i_wb_rty = 1'b0;
        i_wb_dat = '0;
      end else if (o_wb_cyc && o_wb_stb && !mem_stall) begin
        if (wait_left < 0) begin
          // Every access is a full word
          check_flag("o_wb_sel covers all byte lanes", o_wb_sel === '1, 1'b1);
          mem_rng   = lcg_step(mem_rng);
          wait_left = int'(mem_rng[17:16]) % 3;
        end
        if (wait_left == 0) begin
          wait_left = -1;
          mem_rng   = lcg_step(mem_rng);
          if (retry_on && mem_rng[31:30] == 2'b00) begin
            i_wb_rty = 1'b1;
          end else begin
            i_wb_ack = 1'b1;
            if (o_wb_we) begin
              mem[o_wb_adr[7:0]] = o_wb_dat;
            end else begin
              i_wb_dat = mem[o_wb_adr[7:0]];
            end
          end
        end else begin
          wait_left--;
        end
      end
    end
  end

  // Done report monitor
  always @(negedge i_clk) begin
    if (i_arst_n === 1'b1 && o_done_valid === 1'b1) begin
      done_hits[o_done_cmt_id]    = done_hits[o_done_cmt_id] + 1;
      done_is_load[o_done_cmt_id] = o_done_is_load;
      done_data[o_done_cmt_id]    = o_done_data;
      done_ids.push_back(o_done_cmt_id);
    end
  end

  // ----------------------------------------
  // Compare and wait helpers
  // ----------------------------------------
  task automatic check_cmt_id(input string what, input cmt_id_t got, input cmt_id_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR @ %0t: %s, got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input string what, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR @ %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR @ %0t: %s, got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic dispatch_op(input lsu_op_e op, input addr_t addr, input data_t data,
                             output cmt_id_t id);
    int t;
    t             = 0;
    id            = next_id;
    i_disp_valid  = 1'b1;
    i_disp_op     = op;
    i_disp_cmt_id = next_id;
    i_disp_addr   = addr;
    i_disp_data   = data;
    while (!o_disp_ready && t < TIMEOUT_CYC) begin
      @(negedge i_clk);
      t++;
    end
    if (!o_disp_ready) begin
      errors++;
      $display("Timeout at %0t: dispatch of id %0d was never accepted", $time, id);
    end else begin
      next_id++;
      @(negedge i_clk);
    end
    i_disp_valid = 1'b0;
  endtask

  task automatic wait_id_done(input cmt_id_t id);
    int t;
    t = 0;
    while (done_hits[id] == hits0[id] && t < TIMEOUT_CYC) begin
      @(negedge i_clk);
      t++;
    end
    if (done_hits[id] == hits0[id]) begin
      errors++;
      $display("Timeout at %0t: no done report arrived for id %0d", $time, id);
    end
  endtask

  task automatic wait_done_total(input int target);
    int t;
    t = 0;
    while (done_ids.size() < target && t < TIMEOUT_CYC) begin
      @(negedge i_clk);
      t++;
    end
    if (done_ids.size() < target) begin
      errors++;
      $display("Timeout at %0t: only %0d of %0d done reports seen", $time,
               done_ids.size(), target);
    end
    repeat (DRAIN_CYC) @(negedge i_clk);
    check_flag("no extra done reports", done_ids.size() == target, 1'b1);
  endtask

  task automatic snapshot_hits();
    for (int i = 0; i < ID_RANGE; i++) begin
      hits0[i] = done_hits[i];
    end
  endtask

  task automatic check_done(input cmt_id_t id, input logic exp_load, input data_t exp);
    check_flag($sformatf("id %0d reported once", id), done_hits[id] - hits0[id] == 1, 1'b1);
    check_flag($sformatf("id %0d is_load", id), done_is_load[id], exp_load);
    check_data($sformatf("id %0d data", id), done_data[id], exp);
  endtask

  task automatic report_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("%-16s ok", name);
    end else begin
      tests_failed++;
      $display("%-16s failed with %0d errors", name, errors - err0);
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_reset_state();
    int err0;
    err0 = errors;
    check_flag("o_wb_cyc after reset", o_wb_cyc, 1'b0);
    check_flag("o_done_valid after reset", o_done_valid, 1'b0);
    check_flag("o_disp_ready after reset", o_disp_ready, 1'b1);
    report_test("reset_state", err0);
  endtask

  task automatic test_store_load();
    int      err0, base;
    cmt_id_t sid, lid;
    err0 = errors;
    base = done_ids.size();
    snapshot_hits();
    dispatch_op(OP_STORE, 16'h0010, 32'ha5a5_1234, sid);
    dispatch_op(OP_LOAD, 16'h0010, '0, lid);
    wait_done_total(base + 2);
    if (done_ids.size() >= base + 2) begin
      check_cmt_id("first done id", done_ids[base], sid);
      check_cmt_id("second done id", done_ids[base + 1], lid);
    end
    check_done(sid, 1'b0, '0);
    check_done(lid, 1'b1, 32'ha5a5_1234);
    report_test("store_load", err0);
  endtask

  task automatic test_retry_complete();
    int      err0, base;
    cmt_id_t st_id [6];
    cmt_id_t ld_id [6];
    data_t   st_dat [6];
    err0 = errors;
    base = done_ids.size();
    snapshot_hits();
    retry_on = 1'b1;
    for (int k = 0; k < 6; k++) begin
      stim_rng  = lcg_step(stim_rng);
      st_dat[k] = stim_rng;
      dispatch_op(OP_STORE, addr_t'(16'h0020 + k), st_dat[k], st_id[k]);
      wait_id_done(st_id[k]);
      dispatch_op(OP_LOAD, addr_t'(16'h0020 + k), '0, ld_id[k]);
    end
    wait_done_total(base + 12);
    for (int k = 0; k < 6; k++) begin
      check_done(st_id[k], 1'b0, '0);
      check_done(ld_id[k], 1'b1, st_dat[k]);
    end
    retry_on = 1'b0;
    report_test("retry_complete", err0);
  endtask

  task automatic test_backpressure();
    int   err0, base, accepted;
    logic saw_stall;
    err0      = errors;
    base      = done_ids.size();
    accepted  = 0;
    saw_stall = 1'b0;
    mem_stall = 1'b1;
    // Offer a load every cycle while the bus never answers
    for (int n = 0; n < IQ_DEPTH + 4; n++) begin
      i_disp_valid  = 1'b1;
      i_disp_op     = OP_LOAD;
      i_disp_cmt_id = next_id;
      i_disp_addr   = addr_t'(16'h0040 + accepted);
      i_disp_data   = '0;
      if (o_disp_ready) begin
        accepted++;
        next_id++;
      end else begin
        saw_stall = 1'b1;
      end
      @(negedge i_clk);
    end
    i_disp_valid = 1'b0;
    check_flag("o_disp_ready dropped when full", saw_stall, 1'b1);
    mem_stall = 1'b0;
    wait_done_total(base + accepted);
    report_test("backpressure", err0);
  endtask

  task automatic test_random_loads();
    int          err0, base;
    cmt_id_t     ids [12];
    logic [7:0]  word [12];
    err0 = errors;
    base = done_ids.size();
    snapshot_hits();
    retry_on = 1'b1;
    // Upper half of memory still holds the preload
    for (int k = 0; k < 12; k++) begin
      stim_rng = lcg_step(stim_rng);
      word[k]  = 8'h80 | stim_rng[23:16];
      dispatch_op(OP_LOAD, addr_t'(word[k]), '0, ids[k]);
    end
    wait_done_total(base + 12);
    for (int k = 0; k < 12; k++) begin
      check_done(ids[k], 1'b1, fill_word(word[k]));
    end
    retry_on = 1'b0;
    report_test("random_loads", err0);
  endtask

  initial begin
    i_arst_n      = 1'b0;
    i_disp_valid  = 1'b0;
    i_disp_op     = OP_LOAD;
    i_disp_cmt_id = '0;
    i_disp_addr   = '0;
    i_disp_data   = '0;
    retry_on      = 1'b0;
    mem_stall     = 1'b0;
    next_id       = '0;
    errors        = 0;
    checks        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_arst_n = 1'b1;
    test_reset_state();
    test_store_load();
    test_retry_complete();
    test_backpressure();
    test_random_loads();
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/lsu_pipe_chk.sv
// LSU pipe checker: Wishbone handshake rules and done/replay exclusion
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe_chk
  import lsu_cfg_pkg::*;
(
  input wire logic  i_clk,
  input wire logic  i_arst_n,
  input wire logic  i_wb_cyc,
  input wire logic  i_wb_stb,
  input wire addr_t i_wb_adr,
  input wire logic  i_wb_ack,
  input wire logic  i_wb_rty,
  input wire logic  i_done_valid,
  input wire logic  i_rp_push
);

  // Strobe only inside a bus cycle
  a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_wb_stb |-> i_wb_cyc)
    else $error("wishbone stb high while cyc is low");

  // Address held until the slave answers
  a_adr_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_wb_cyc && !i_wb_ack && !i_wb_rty) |=> $stable(i_wb_adr))
    else $error("wishbone address changed before ack or rty");

  // An access either completes or replays, never both
  a_done_or_replay: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(i_done_valid && i_rp_push))
    else $error("done report and replay push in the same cycle");

endmodule

bind lsu_pipe lsu_pipe_chk u_pipe_chk (
  .i_clk        (i_clk),
  .i_arst_n     (i_arst_n),
  .i_wb_cyc     (o_wb_cyc),
  .i_wb_stb     (o_wb_stb),
  .i_wb_adr     (o_wb_adr),
  .i_wb_ack     (i_wb_ack),
  .i_wb_rty     (i_wb_rty),
  .i_done_valid (o_done_valid),
  .i_rp_push    (o_rp_push)
);

`default_nettype wire

//--- source/lsu_top.sv
// LSU top: issue and replay queues, oldest-first selection into the pipe
`timescale 1ns/1ps
`default_nettype none

module lsu_top
  import lsu_cfg_pkg::*;
  import lsu_ctl_pkg::*;
#(
  parameter int IQ_DEPTH = 4,
  parameter int RQ_DEPTH = 4
) (
  input  wire logic    i_clk,
  input  wire logic    i_arst_n,

  input  wire logic    i_disp_valid,
  input  wire lsu_op_e i_disp_op,
  input  wire cmt_id_t i_disp_cmt_id,
  input  wire addr_t   i_disp_addr,
  input  wire data_t   i_disp_data,
  output logic         o_disp_ready,

  output logic         o_wb_cyc,
  output logic         o_wb_stb,
  output logic         o_wb_we,
  output addr_t        o_wb_adr,
  output data_t        o_wb_dat,
  output logic [SEL_W-1:0] o_wb_sel,
  input  wire data_t   i_wb_dat,
  input  wire logic    i_wb_ack,
  input  wire logic    i_wb_rty,

  output logic         o_done_valid,
  output cmt_id_t      o_done_cmt_id,
  output logic         o_done_is_load,
  output data_t        o_done_data
);

  logic    iq_valid, iq_oldest, iq_take;
  lsu_op_e iq_op;
  cmt_id_t iq_cmt_id;
  addr_t   iq_addr;
  data_t   iq_data;

  logic    rq_valid, rq_high_pri, rq_almost_full, rq_take;
  lsu_op_e rq_op;
  cmt_id_t rq_cmt_id;
  addr_t   rq_addr;
  data_t   rq_data;

  logic    rp_push;
  lsu_op_e rp_op;
  cmt_id_t rp_cmt_id;
  addr_t   rp_addr;
  data_t   rp_data;
  haz_e    rp_haz;

  logic    replay_sel;
  logic    ex0_valid, ex0_ready, ex0_high_pri;
  lsu_op_e ex0_op;
  cmt_id_t ex0_cmt_id;
  addr_t   ex0_addr;
  data_t   ex0_data;

  lsu_issue_queue #(
    .IQ_DEPTH (IQ_DEPTH)
  ) u_issue_queue (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_disp_valid  (i_disp_valid),
    .i_disp_op     (i_disp_op),
    .i_disp_cmt_id (i_disp_cmt_id),
    .i_disp_addr   (i_disp_addr),
    .i_disp_data   (i_disp_data),
    .o_disp_ready  (o_disp_ready),
    .i_take        (iq_take),
    .i_rq_valid    (rq_valid),
    .i_rq_cmt_id   (rq_cmt_id),
    .o_iss_valid   (iq_valid),
    .o_iss_op      (iq_op),
    .o_iss_cmt_id  (iq_cmt_id),
    .o_iss_addr    (iq_addr),
    .o_iss_data    (iq_data),
    .o_iss_oldest  (iq_oldest)
  );

  lsu_replay_queue #(
    .RQ_DEPTH (RQ_DEPTH)
  ) u_replay_queue (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_push        (rp_push),
    .i_push_op     (rp_op),
    .i_push_cmt_id (rp_cmt_id),
    .i_push_addr   (rp_addr),
    .i_push_data   (rp_data),
    .i_push_haz    (rp_haz),
    .i_take        (rq_take),
    .o_rq_valid    (rq_valid),
    .o_rq_op       (rq_op),
    .o_rq_cmt_id   (rq_cmt_id),
    .o_rq_addr     (rq_addr),
    .o_rq_data     (rq_data),
    .o_rq_high_pri (rq_high_pri),
    .o_almost_full (rq_almost_full)
  );

  // ----------------------------------------
  // Oldest-first selection
  // ----------------------------------------
  // Replay also wins when it is nearly full and the issue head is not the
  // oldest op, so the replay queue drains before it can overflow
  assign replay_sel = rq_valid &&
                      (!iq_valid || id0_is_older(rq_cmt_id, iq_cmt_id) ||
                       (rq_almost_full && !iq_oldest));

  always_comb begin
    if (replay_sel) begin
      ex0_valid    = rq_valid;
      ex0_op       = rq_op;
      ex0_cmt_id   = rq_cmt_id;
      ex0_addr     = rq_addr;
      ex0_data     = rq_data;
      ex0_high_pri = rq_high_pri;
    end else begin
      ex0_valid    = iq_valid;
      ex0_op       = iq_op;
      ex0_cmt_id   = iq_cmt_id;
      ex0_addr     = iq_addr;
      ex0_data     = iq_data;
      ex0_high_pri = 1'b0;
    end
  end

  assign rq_take = replay_sel && ex0_ready;
  assign iq_take = !replay_sel && ex0_valid && ex0_ready;

  lsu_pipe u_lsu_pipe (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_ex0_valid    (ex0_valid),
    .i_ex0_op       (ex0_op),
    .i_ex0_cmt_id   (ex0_cmt_id),
    .i_ex0_addr     (ex0_addr),
    .i_ex0_data     (ex0_data),
    .i_ex0_high_pri (ex0_high_pri),
    .o_ex0_ready    (ex0_ready),
    .o_wb_cyc       (o_wb_cyc),
    .o_wb_stb       (o_wb_stb),
    .o_wb_we        (o_wb_we),
    .o_wb_adr       (o_wb_adr),
    .o_wb_dat       (o_wb_dat),
    .o_wb_sel       (o_wb_sel),
    .i_wb_dat       (i_wb_dat),
    .i_wb_ack       (i_wb_ack),
    .i_wb_rty       (i_wb_rty),
    .o_done_valid   (o_done_valid),
    .o_done_cmt_id  (o_done_cmt_id),
    .o_done_is_load (o_done_is_load),
    .o_done_data    (o_done_data),
    .o_rp_push      (rp_push),
    .o_rp_op        (rp_op),
    .o_rp_cmt_id    (rp_cmt_id),
    .o_rp_addr      (rp_addr),
    .o_rp_data      (rp_data),
    .o_rp_haz       (rp_haz)
  );

endmodule

`default_nettype wire

//--- source/lsu_pipe.sv
// LSU memory pipe: ex0 register and Wishbone bus stage with done and replay
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe
  import lsu_cfg_pkg::*;
  import lsu_ctl_pkg::*;
(
  input  wire logic    i_clk,
  input  wire logic    i_arst_n,

  // ex0 request
  input  wire logic    i_ex0_valid,
  input  wire lsu_op_e i_ex0_op,
  input  wire cmt_id_t i_ex0_cmt_id,
  input  wire addr_t   i_ex0_addr,
  input  wire data_t   i_ex0_data,
  input  wire logic    i_ex0_high_pri,
  output logic         o_ex0_ready,

  // Wishbone classic master
  output logic         o_wb_cyc,
  output logic         o_wb_stb,
  output logic         o_wb_we,
  output addr_t        o_wb_adr,
  output data_t        o_wb_dat,
  output logic [SEL_W-1:0] o_wb_sel,
  input  wire data_t   i_wb_dat,
  input  wire logic    i_wb_ack,
  input  wire logic    i_wb_rty,

  // Done report
  output logic         o_done_valid,
  output cmt_id_t      o_done_cmt_id,
  output logic         o_done_is_load,
  output data_t        o_done_data,

  // Replay push
  output logic         o_rp_push,
  output lsu_op_e      o_rp_op,
  output cmt_id_t      o_rp_cmt_id,
  output addr_t        o_rp_addr,
  output data_t        o_rp_data,
  output haz_e         o_rp_haz
);

  logic       ex0_valid;
  lsu_op_e    ex0_op;
  cmt_id_t    ex0_cmt_id;
  addr_t      ex0_addr;
  data_t      ex0_data;
  logic       ex0_high_pri;

  bus_state_e bus_state;
  logic       bus_rty;
  lsu_op_e    bus_op;
  cmt_id_t    bus_cmt_id;
  addr_t      bus_addr;
  data_t      bus_data;
  data_t      bus_rdata;

  logic       bus_free;
  logic       start;
  logic       use_in;
  logic       ex0_move;
  logic       ex0_load;
  logic       bus_end;

  // ----------------------------------------
  // ex0 stage
  // ----------------------------------------
  // The DONE cycle is the gap with cyc low, a new access may start in it
  assign bus_free = (bus_state != BUS_CYC);
  assign bus_end  = (bus_state == BUS_CYC) && (i_wb_ack || i_wb_rty);

  // Incoming op goes straight to the bus when ex0 is empty, or when it is
  // a replay overtaking a waiting new issue
  assign use_in   = i_ex0_valid && (!ex0_valid || (i_ex0_high_pri && !ex0_high_pri));
  assign start    = bus_free && (ex0_valid || i_ex0_valid);
  assign ex0_move = start && !use_in;

  assign o_ex0_ready = !ex0_valid || bus_free;
  assign ex0_load    = i_ex0_valid && o_ex0_ready && !(start && use_in);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ex0_valid <= 1'b0;
    end else if (ex0_load) begin
      ex0_valid <= 1'b1;
    end else if (ex0_move) begin
      ex0_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (ex0_load) begin
      ex0_op       <= i_ex0_op;
      ex0_cmt_id   <= i_ex0_cmt_id;
      ex0_addr     <= i_ex0_addr;
      ex0_data     <= i_ex0_data;
      ex0_high_pri <= i_ex0_high_pri;
    end
  end

  // ----------------------------------------
  // Bus stage
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      bus_state <= BUS_IDLE;
      bus_rty   <= 1'b0;
    end else begin
      case (bus_state)
        BUS_CYC: begin
          if (bus_end) begin
            bus_state <= BUS_DONE;
            bus_rty   <= i_wb_rty && !i_wb_ack;
          end
        end
        default: begin
          bus_state <= start ? BUS_CYC : BUS_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (start) begin
      bus_op     <= use_in ? i_ex0_op     : ex0_op;
      bus_cmt_id <= use_in ? i_ex0_cmt_id : ex0_cmt_id;
      bus_addr   <= use_in ? i_ex0_addr   : ex0_addr;
      bus_data   <= use_in ? i_ex0_data   : ex0_data;
    end
    if (bus_end) begin
      bus_rdata <= i_wb_dat;
    end
  end

  assign o_wb_cyc = (bus_state == BUS_CYC);
  assign o_wb_stb = (bus_state == BUS_CYC);
  assign o_wb_we  = (bus_op == OP_STORE);
  assign o_wb_adr = bus_addr;
  assign o_wb_dat = bus_data;
  assign o_wb_sel = '1;

  // Results, one cycle after ack or rty
  assign o_done_valid   = (bus_state == BUS_DONE) && !bus_rty;
  assign o_done_cmt_id  = bus_cmt_id;
  assign o_done_is_load = (bus_op == OP_LOAD);
  assign o_done_data    = o_done_is_load ? bus_rdata : '0;

  assign o_rp_push   = (bus_state == BUS_DONE) && bus_rty;
  assign o_rp_op     = bus_op;
  assign o_rp_cmt_id = bus_cmt_id;
  assign o_rp_addr   = bus_addr;
  assign o_rp_data   = bus_data;
  assign o_rp_haz    = o_rp_push ? HAZ_RETRY : HAZ_NONE;

endmodule

`default_nettype wire

//--- source/lsu_replay_queue.sv
// LSU replay queue: holds retried operations and re-offers the oldest one
`timescale 1ns/1ps
`default_nettype none

module lsu_replay_queue
  import lsu_cfg_pkg::*;
  import lsu_ctl_pkg::*;
#(
  parameter int RQ_DEPTH = 4
) (
  input  wire logic    i_clk,
  input  wire logic    i_arst_n,

  // Push from the pipe
  input  wire logic    i_push,
  input  wire lsu_op_e i_push_op,
  input  wire cmt_id_t i_push_cmt_id,
  input  wire addr_t   i_push_addr,
  input  wire data_t   i_push_data,
  input  wire haz_e    i_push_haz,

  // Offer to the top
  input  wire logic    i_take,
  output logic         o_rq_valid,
  output lsu_op_e      o_rq_op,
  output cmt_id_t      o_rq_cmt_id,
  output addr_t        o_rq_addr,
  output data_t        o_rq_data,
  output logic         o_rq_high_pri,
  output logic         o_almost_full
);

  localparam int IDX_W  = $clog2(RQ_DEPTH);
  localparam int LEAVES = 1 << IDX_W;
  localparam int CNT_W  = $clog2(RQ_DEPTH + 1);

  logic [RQ_DEPTH-1:0] ent_valid;
  lsu_op_e             ent_op      [RQ_DEPTH];
  cmt_id_t             ent_cmt_id  [RQ_DEPTH];
  addr_t               ent_addr    [RQ_DEPTH];
  data_t               ent_data    [RQ_DEPTH];
  logic                ent_hi_pri  [RQ_DEPTH];

  logic [LEAVES-1:0]   leaf_v;
  logic                node_v      [1:2*LEAVES-1];
  cmt_id_t             node_id     [1:2*LEAVES-1];
  logic [IDX_W-1:0]    node_idx    [1:2*LEAVES-1];
  logic [IDX_W-1:0]    sel_idx;
  logic [IDX_W-1:0]    free_idx;
  logic [CNT_W-1:0]    valid_cnt;

  // ----------------------------------------
  // Oldest entry, comparison tree
  // ----------------------------------------
  assign leaf_v = LEAVES'(ent_valid);

  always_comb begin
    for (int i = 0; i < LEAVES; i++) begin
      node_v[LEAVES+i]   = leaf_v[i];
      node_id[LEAVES+i]  = ent_cmt_id[i % RQ_DEPTH];
      node_idx[LEAVES+i] = IDX_W'(i % RQ_DEPTH);
    end
    for (int n = LEAVES - 1; n >= 1; n--) begin
      // Right child wins only when it is valid and strictly older
      if (node_v[2*n+1] && (!node_v[2*n] || id0_is_older(node_id[2*n+1], node_id[2*n]))) begin
        node_id[n]  = node_id[2*n+1];
        node_idx[n] = node_idx[2*n+1];
      end else begin
        node_id[n]  = node_id[2*n];
        node_idx[n] = node_idx[2*n];
      end
      node_v[n] = node_v[2*n] | node_v[2*n+1];
    end
  end

  assign sel_idx       = node_idx[1];
  assign o_rq_valid    = node_v[1];
  assign o_rq_op       = ent_op[sel_idx];
  assign o_rq_cmt_id   = ent_cmt_id[sel_idx];
  assign o_rq_addr     = ent_addr[sel_idx];
  assign o_rq_data     = ent_data[sel_idx];
  assign o_rq_high_pri = ent_hi_pri[sel_idx];

  // First free slot and occupancy
  always_comb begin
    free_idx  = '0;
    valid_cnt = '0;
    for (int i = RQ_DEPTH - 1; i >= 0; i--) begin
      if (!ent_valid[i]) begin
        free_idx = IDX_W'(i);
      end
      valid_cnt = valid_cnt + CNT_W'(ent_valid[i]);
    end
  end

  // One or no free slot left
  assign o_almost_full = (int'(valid_cnt) >= RQ_DEPTH - 1);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ent_valid <= '0;
    end else begin
      if (i_take && o_rq_valid) begin
        ent_valid[sel_idx] <= 1'b0;
      end
      if (i_push) begin
        ent_valid[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      ent_op[free_idx]     <= i_push_op;
      ent_cmt_id[free_idx] <= i_push_cmt_id;
      ent_addr[free_idx]   <= i_push_addr;
      ent_data[free_idx]   <= i_push_data;
      ent_hi_pri[free_idx] <= (i_push_haz == HAZ_RETRY);
    end
  end

endmodule

`default_nettype wire

//--- source/lsu_issue_queue.sv
// LSU issue queue: in-order buffer of dispatched operations, offers the head
`timescale 1ns/1ps
`default_nettype none

module lsu_issue_queue
  import lsu_cfg_pkg::*;
  import lsu_ctl_pkg::*;
#(
  parameter int IQ_DEPTH = 4
) (
  input  wire logic    i_clk,
  input  wire logic    i_arst_n,

  // Dispatch
  input  wire logic    i_disp_valid,
  input  wire lsu_op_e i_disp_op,
  input  wire cmt_id_t i_disp_cmt_id,
  input  wire addr_t   i_disp_addr,
  input  wire data_t   i_disp_data,
  output logic         o_disp_ready,

  // Issue side
  input  wire logic    i_take,
  input  wire logic    i_rq_valid,
  input  wire cmt_id_t i_rq_cmt_id,
  output logic         o_iss_valid,
  output lsu_op_e      o_iss_op,
  output cmt_id_t      o_iss_cmt_id,
  output addr_t        o_iss_addr,
  output data_t        o_iss_data,
  output logic         o_iss_oldest
);

  localparam int PTR_W = $clog2(IQ_DEPTH);
  localparam int CNT_W = $clog2(IQ_DEPTH + 1);

  lsu_op_e            ent_op     [IQ_DEPTH];
  cmt_id_t            ent_cmt_id [IQ_DEPTH];
  addr_t              ent_addr   [IQ_DEPTH];
  data_t              ent_data   [IQ_DEPTH];

  logic [PTR_W-1:0]   head;
  logic [PTR_W-1:0]   tail;
  logic [CNT_W-1:0]   count;
  logic               push;
  logic               pop;

  assign o_disp_ready = (count != CNT_W'(IQ_DEPTH));
  assign push         = i_disp_valid & o_disp_ready;
  assign pop          = i_take & o_iss_valid;

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= (tail == PTR_W'(IQ_DEPTH - 1)) ? '0 : tail + 1'b1;
      end
      if (pop) begin
        head <= (head == PTR_W'(IQ_DEPTH - 1)) ? '0 : head + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Entry payload
  always_ff @(posedge i_clk) begin
    if (push) begin
      ent_op[tail]     <= i_disp_op;
      ent_cmt_id[tail] <= i_disp_cmt_id;
      ent_addr[tail]   <= i_disp_addr;
      ent_data[tail]   <= i_disp_data;
    end
  end

  // ----------------------------------------
  // Head offer
  // ----------------------------------------
  // Dispatch is in order, so the head is the oldest entry held here
  assign o_iss_valid  = (count != '0);
  assign o_iss_op     = ent_op[head];
  assign o_iss_cmt_id = ent_cmt_id[head];
  assign o_iss_addr   = ent_addr[head];
  assign o_iss_data   = ent_data[head];

  // Oldest in flight unless replay holds something older
  assign o_iss_oldest = !i_rq_valid || id0_is_older(ent_cmt_id[head], i_rq_cmt_id);

endmodule

`default_nettype wire

//--- source/lsu_ctl_pkg.sv
// LSU control encodings: operation kind, hazard kind and bus FSM states
`default_nettype none

package lsu_ctl_pkg;

  // Operation kind carried with every request
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } lsu_op_e;

  // Reason an operation was sent to replay
  typedef enum logic [1:0] {
    HAZ_NONE  = 2'd0,
    HAZ_RETRY = 2'd1
  } haz_e;

  // Pipe bus stage
  typedef enum logic [1:0] {
    BUS_IDLE = 2'd0,
    BUS_CYC  = 2'd1,
    BUS_DONE = 2'd2
  } bus_state_e;

endpackage

`default_nettype wire

//--- source/lsu_cfg_pkg.sv
// LSU configuration: data path widths, vector types and commit-age compare
`default_nettype none

package lsu_cfg_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int ADDR_W   = 16;
  localparam int DATA_W   = 32;
  localparam int CMT_ID_W = 5;
  localparam int SEL_W    = DATA_W / 8;

  // Half of the id range, the most ids that may be in flight
  localparam int HALF_IDS = 1 << (CMT_ID_W - 1);

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [CMT_ID_W-1:0] cmt_id_t;

  // ----------------------------------------
  // Commit age
  // ----------------------------------------
  // Ids come in program order and wrap, so age is judged on the wrapped
  // distance from id0 forward to id1
  function automatic logic id0_is_older(input cmt_id_t id0, input cmt_id_t id1);
    cmt_id_t diff;
    diff = id1 - id0;
    return (diff != '0) && (int'(diff) < HALF_IDS);
  endfunction

endpackage

`default_nettype wire
